// ==== verilog/mrd_pkg.sv ====
package mrd_pkg;

	localparam int ADDR_W = 12;
	localparam int DATA_W = 16;
	localparam int NUM_BANKS = 7;
	localparam int BANK_W = 3;
	localparam int MAX_FACTORS = 6;
	localparam int RADIX_W = 3;

	// APB addresses are byte addresses, registers decode on the word offset paddr[APB_AW-1:2]
	localparam int APB_AW = 16;
	localparam int WORD_W = APB_AW - 2;

	localparam logic [WORD_W-1:0] REG_SIZE = 14'h0000;
	localparam logic [WORD_W-1:0] REG_FACTORS = 14'h0001;
	localparam logic [WORD_W-1:0] REG_CTRL = 14'h0002;
	localparam logic [WORD_W-1:0] REG_STATUS = 14'h0003;
	// Sample k is written at word offset SAMPLE_BASE + k
	localparam logic [WORD_W-1:0] SAMPLE_BASE = 14'h0400;

	typedef struct packed {
		logic [31-RADIX_W-ADDR_W:0] pad;
		logic [RADIX_W-1:0] num_factors;
		logic [ADDR_W-1:0] dftpts;
	} size_cfg_t;

	// Field nf[0] holds the radix of the fastest digit
	typedef struct packed {
		logic [31-MAX_FACTORS*RADIX_W:0] pad;
		logic [MAX_FACTORS-1:0][RADIX_W-1:0] nf;
	} factor_cfg_t;

	// One APB write word, read as a size word or a factor word by register
	typedef union packed {
		size_cfg_t size;
		factor_cfg_t factor;
	} cfg_word_u;

	typedef struct packed {
		logic [NUM_BANKS-1:0] rden;
		logic [ADDR_W-1:0] row;
	} bank_rd_t;

	typedef struct packed {
		logic en;
		logic [BANK_W-1:0] bank;
		logic [ADDR_W-1:0] row;
		logic [DATA_W-1:0] data;
	} sample_wr_t;

	typedef struct packed {
		logic valid;
		logic sop;
		logic eop;
		logic [DATA_W-1:0] data;
	} src_stream_t;

endpackage

// ==== verilog/mrd_apb_regs.sv ====
`timescale 1ns/100ps

module mrd_apb_regs #(
	parameter int BANK_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [mrd_pkg::APB_AW-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic busy,
	output mrd_pkg::size_cfg_t size_cfg,
	output mrd_pkg::factor_cfg_t factor_cfg,
	output logic start,
	output mrd_pkg::sample_wr_t sample_wr
);

	localparam int AW = mrd_pkg::ADDR_W;
	localparam int BW = mrd_pkg::BANK_W;
	localparam int SAMPLES = mrd_pkg::NUM_BANKS * BANK_DEPTH;

	logic [mrd_pkg::WORD_W-1:0] word;
	logic [mrd_pkg::WORD_W-1:0] sample_off;
	logic [AW-1:0] sample_idx;
	logic reg_hit;
	logic sample_hit;
	logic access;
	logic wr_en;
	mrd_pkg::cfg_word_u wr_word;

	assign word = paddr[mrd_pkg::APB_AW-1:2];
	assign sample_off = word - mrd_pkg::SAMPLE_BASE;
	assign sample_idx = AW'(sample_off);

	assign reg_hit = (word == mrd_pkg::REG_SIZE) || (word == mrd_pkg::REG_FACTORS) ||
		(word == mrd_pkg::REG_CTRL) || (word == mrd_pkg::REG_STATUS);
	// The sample window only covers indices that fit the seven banks
	assign sample_hit = (word >= mrd_pkg::SAMPLE_BASE) && (int'(sample_off) < SAMPLES);

	assign access = psel && penable;
	assign wr_en = access && pwrite;
	assign wr_word = pwdata;

	assign pready = 1'b1;
	assign pslverr = access && !(reg_hit || sample_hit);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			size_cfg <= '0;
			factor_cfg <= '0;
			start <= 1'b0;
		end
		else
		begin
			start <= wr_en && (word == mrd_pkg::REG_CTRL) && pwdata[0] && !busy;
			if (wr_en && (word == mrd_pkg::REG_SIZE))
			begin
				size_cfg.dftpts <= wr_word.size.dftpts;
				size_cfg.num_factors <= wr_word.size.num_factors;
			end
			if (wr_en && (word == mrd_pkg::REG_FACTORS))
				factor_cfg.nf <= wr_word.factor.nf;
		end
	end

	// The start bit of the control register clears itself and always reads zero
	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			case (word)
				mrd_pkg::REG_SIZE: prdata = size_cfg;
				mrd_pkg::REG_FACTORS: prdata = factor_cfg;
				mrd_pkg::REG_STATUS: prdata = {31'd0, busy};
				default: prdata = '0;
			endcase
		end
	end

	// Sample k goes to bank k mod 7 at row k div 7
	assign sample_wr.en = wr_en && sample_hit;
	assign sample_wr.bank = BW'(sample_idx % AW'(mrd_pkg::NUM_BANKS));
	assign sample_wr.row = sample_idx / AW'(mrd_pkg::NUM_BANKS);
	assign sample_wr.data = pwdata[mrd_pkg::DATA_W-1:0];

endmodule

// ==== verilog/mrd_cta_addr.sv ====
`timescale 1ns/100ps

module mrd_cta_addr (
	input  logic clk,
	input  logic rst_n,
	input  logic addr_run,
	input  mrd_pkg::factor_cfg_t factor_cfg,
	input  logic [mrd_pkg::RADIX_W-1:0] num_factors,
	output logic [mrd_pkg::ADDR_W-1:0] addr
);

	localparam int AW = mrd_pkg::ADDR_W;
	localparam int NF = mrd_pkg::MAX_FACTORS;

	logic [NF-1:0][mrd_pkg::RADIX_W-1:0] digit;
	logic [NF-1:0][mrd_pkg::RADIX_W-1:0] digit_nx;
	logic [NF-1:0][AW-1:0] weight;
	logic [AW-1:0] addr_nx;

	// Digit i is weighted by the product of the radices above it, so the top digit has weight 1
	always_comb
	begin : weight_calc
		logic [AW-1:0] w;
		w = AW'(1);
		for (int i = NF - 1; i >= 0; i--)
		begin
			if (i < int'(num_factors))
			begin
				weight[i] = w;
				w = w * AW'(factor_cfg.nf[i]);
			end
			else
				weight[i] = '0;
		end
	end

	// Ripple the increment from digit 0 upward
	// A digit that rolls over takes its whole contribution back out of the address
	always_comb
	begin : digit_step
		logic carry;
		carry = 1'b1;
		digit_nx = digit;
		addr_nx = addr;
		for (int i = 0; i < NF; i++)
		begin
			if (carry && (i < int'(num_factors)))
			begin
				if (digit[i] == factor_cfg.nf[i] - 1'b1)
				begin
					digit_nx[i] = '0;
					addr_nx = addr_nx - AW'(digit[i]) * weight[i];
				end
				else
				begin
					digit_nx[i] = digit[i] + 1'b1;
					addr_nx = addr_nx + weight[i];
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || !addr_run)
		begin
			digit <= '0;
			addr <= '0;
		end
		else
		begin
			digit <= digit_nx;
			addr <= addr_nx;
		end
	end

endmodule

// ==== verilog/mrd_bank_map.sv ====
`timescale 1ns/100ps

module mrd_bank_map (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic [mrd_pkg::ADDR_W-1:0] addr,
	output mrd_pkg::bank_rd_t bank_rd
);

	localparam int AW = mrd_pkg::ADDR_W;
	localparam int BW = mrd_pkg::BANK_W;
	localparam int NB = mrd_pkg::NUM_BANKS;

	logic [BW-1:0] bank_idx;
	logic [NB-1:0] onehot;

	assign bank_idx = BW'(addr % AW'(NB));

	// Bank 0 sits on the top bit of rden
	assign onehot = {1'b1, {(NB - 1){1'b0}}} >> bank_idx;

	always_ff @(posedge clk)
	begin
		bank_rd.row <= addr / AW'(NB);
		if (!rst_n)
			bank_rd.rden <= '0;
		else
			bank_rd.rden <= run ? onehot : '0;
	end

endmodule

// ==== verilog/mrd_bank_ram.sv ====
`timescale 1ns/100ps

module mrd_bank_ram #(
	parameter int BANK_DEPTH = 64
) (
	input  logic clk,
	input  mrd_pkg::sample_wr_t sample_wr,
	input  mrd_pkg::bank_rd_t bank_rd,
	output logic [mrd_pkg::DATA_W-1:0] rd_data
);

	localparam int ROW_W = $clog2(BANK_DEPTH);
	localparam int NB = mrd_pkg::NUM_BANKS;

	logic [mrd_pkg::DATA_W-1:0] mem [NB][BANK_DEPTH];
	logic [ROW_W-1:0] wr_row;
	logic [ROW_W-1:0] rd_row;

	assign wr_row = sample_wr.row[ROW_W-1:0];
	assign rd_row = bank_rd.row[ROW_W-1:0];

	always_ff @(posedge clk)
	begin
		if (sample_wr.en)
			mem[sample_wr.bank][wr_row] <= sample_wr.data;
	end

	// Read data holds its last value when no bank is enabled
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < NB; b++)
		begin
			if (bank_rd.rden[NB-1-b])
				rd_data <= mem[b][rd_row];
		end
	end

endmodule

// ==== verilog/mrd_source_ctrl.sv ====
`timescale 1ns/100ps

module mrd_source_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  mrd_pkg::size_cfg_t size_cfg,
	output logic addr_run,
	input  logic [mrd_pkg::DATA_W-1:0] rd_data,
	output mrd_pkg::src_stream_t src_out,
	output logic busy,
	output logic source_end
);

	logic [mrd_pkg::ADDR_W-1:0] beat_cnt;
	logic first_beat;
	logic last_beat;
	// Beat flags as they travel beside the address through the map and RAM stages
	logic [1:0] valid_d;
	logic [1:0] sop_d;
	logic [1:0] eop_d;

	assign first_beat = addr_run && (beat_cnt == '0);
	assign last_beat = addr_run && (beat_cnt == size_cfg.dftpts - 1'b1);

	// One address cycle per point, starting the cycle after the start pulse
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			addr_run <= 1'b0;
			beat_cnt <= '0;
		end
		else if (start)
		begin
			addr_run <= 1'b1;
			beat_cnt <= '0;
		end
		else if (addr_run)
		begin
			beat_cnt <= beat_cnt + 1'b1;
			if (last_beat)
				addr_run <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_d <= '0;
			sop_d <= '0;
			eop_d <= '0;
		end
		else
		begin
			valid_d <= {valid_d[0], addr_run};
			sop_d <= {sop_d[0], first_beat};
			eop_d <= {eop_d[0], last_beat};
		end
	end

	// Output stage, the third flag delay, lines up with the registered RAM data
	always_ff @(posedge clk)
	begin
		src_out.data <= rd_data;
		if (!rst_n)
		begin
			src_out.valid <= 1'b0;
			src_out.sop <= 1'b0;
			src_out.eop <= 1'b0;
			source_end <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			src_out.valid <= valid_d[1];
			src_out.sop <= sop_d[1];
			src_out.eop <= eop_d[1];
			source_end <= src_out.eop;
			// Busy drops after the end pulse has been seen
			if (start)
				busy <= 1'b1;
			else if (source_end)
				busy <= 1'b0;
		end
	end

endmodule

// ==== verilog/mrd_source_top.sv ====
`timescale 1ns/100ps

module mrd_source_top #(
	parameter int BANK_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [mrd_pkg::APB_AW-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output mrd_pkg::src_stream_t src_out,
	output logic source_end
);

	logic busy;
	logic start;
	logic addr_run;
	mrd_pkg::size_cfg_t size_cfg;
	mrd_pkg::factor_cfg_t factor_cfg;
	mrd_pkg::sample_wr_t sample_wr;
	mrd_pkg::bank_rd_t bank_rd;
	logic [mrd_pkg::ADDR_W-1:0] addr;
	logic [mrd_pkg::DATA_W-1:0] rd_data;

	mrd_apb_regs #(
		.BANK_DEPTH(BANK_DEPTH)
	) u_apb_regs (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.size_cfg(size_cfg),
		.factor_cfg(factor_cfg),
		.start(start),
		.sample_wr(sample_wr)
	);

	mrd_source_ctrl u_source_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.size_cfg(size_cfg),
		.addr_run(addr_run),
		.rd_data(rd_data),
		.src_out(src_out),
		.busy(busy),
		.source_end(source_end)
	);

	mrd_cta_addr u_cta_addr (
		.clk(clk),
		.rst_n(rst_n),
		.addr_run(addr_run),
		.factor_cfg(factor_cfg),
		.num_factors(size_cfg.num_factors),
		.addr(addr)
	);

	// The map stage samples addr_run alongside the address it qualifies
	mrd_bank_map u_bank_map (
		.clk(clk),
		.rst_n(rst_n),
		.run(addr_run),
		.addr(addr),
		.bank_rd(bank_rd)
	);

	mrd_bank_ram #(
		.BANK_DEPTH(BANK_DEPTH)
	) u_bank_ram (
		.clk(clk),
		.sample_wr(sample_wr),
		.bank_rd(bank_rd),
		.rd_data(rd_data)
	);

endmodule

// ==== tests/tb_clk.sv ====
`timescale 1ns/100ps

module tb_clk #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// ==== tests/mrd_source_tb.sv ====
`timescale 1ns/100ps

module mrd_source_tb;

	localparam int BANK_DEPTH = 64;
	localparam int SAMPLES = mrd_pkg::NUM_BANKS * BANK_DEPTH;
	// Frames of 7, 60, 60 and 12 beats, each with latency and settling time
	localparam int FRAME_CYCLES = (7 + 60 + 60 + 12) + 4 * 20;
	// Every APB transfer takes three cycles, samples plus register traffic
	localparam int APB_CYCLES = 3 * ((7 + 60 + 12) + 40);
	localparam int RUN_LIMIT = 2 * (FRAME_CYCLES + APB_CYCLES) + 16;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [mrd_pkg::APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	mrd_pkg::src_stream_t src_out;
	logic source_end;

	int cyc = 0;
	int start_cyc;
	int value_errs = 0;
	int other_errs = 0;
	logic [31:0] rng = 32'h6135e93c;
	logic [mrd_pkg::DATA_W-1:0] ref_mem [SAMPLES];
	int cfg_pts;
	int cfg_m;
	int cfg_radix [mrd_pkg::MAX_FACTORS];
	mrd_pkg::src_stream_t beats [$];
	int beat_cyc [$];
	int end_cyc [$];

	tb_clk #(
		.PERIOD(4)
	) u_clk (
		.clk(clk)
	);

	mrd_source_top #(
		.BANK_DEPTH(BANK_DEPTH)
	) i_mrd_source_top (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.src_out(src_out),
		.source_end(source_end)
	);

	always @(posedge clk)
	begin
		cyc = cyc + 1;
		if (cyc >= RUN_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Records every valid stream beat and every end pulse with its cycle
	always @(negedge clk)
	begin
		if (rst_n && src_out.valid)
		begin
			beats.push_back(src_out);
			beat_cyc.push_back(cyc);
		end
		if (rst_n && source_end)
			end_cyc.push_back(cyc);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] reg_addr(input logic [13:0] word);
		return {word, 2'b00};
	endfunction

	function automatic logic [15:0] sample_addr(input int k);
		logic [13:0] word;
		word = mrd_pkg::SAMPLE_BASE + 14'(k);
		return {word, 2'b00};
	endfunction

	// Splits beat n into digits with digit 0 fastest and weights them in reverse order
	function automatic int ref_addr(input int n);
		int rest;
		int a;
		int d;
		rest = n;
		a = 0;
		for (int i = 0; i < cfg_m; i++)
		begin
			d = rest % cfg_radix[i];
			rest = rest / cfg_radix[i];
			a = a * cfg_radix[i] + d;
		end
		return a;
	endfunction

	task automatic report_failure(input string what);
		other_errs++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic check_stream(input mrd_pkg::src_stream_t got,
		input mrd_pkg::src_stream_t exp, input string name);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %0t %s got v=%b sop=%b eop=%b data=%h exp v=%b sop=%b eop=%b data=%h",
				$time, name, got.valid, got.sop, got.eop, got.data,
				exp.valid, exp.sop, exp.eop, exp.data);
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		check_bit(pready, 1'b1, "pready");
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		check_bit(pready, 1'b1, "pready");
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_status(input logic busy_exp);
		logic [31:0] data;
		logic err;
		apb_read(reg_addr(mrd_pkg::REG_STATUS), data, err);
		check_word(data, {31'd0, busy_exp}, "status");
		check_bit(err, 1'b0, "pslverr");
	endtask

	task automatic write_config(input int pts, input int m, input int r0, input int r1,
		input int r2);
		mrd_pkg::cfg_word_u w;
		logic [31:0] exp;
		logic [31:0] data;
		logic err;
		cfg_pts = pts;
		cfg_m = m;
		cfg_radix = '{r0, r1, r2, 0, 0, 0};
		w = '0;
		w.size.dftpts = 12'(pts);
		w.size.num_factors = 3'(m);
		apb_write(reg_addr(mrd_pkg::REG_SIZE), w, err);
		check_bit(err, 1'b0, "pslverr");
		w = '0;
		exp = '0;
		for (int i = 0; i < mrd_pkg::MAX_FACTORS; i++)
		begin
			w.factor.nf[i] = 3'(cfg_radix[i]);
			exp = exp | (32'(cfg_radix[i]) << (3 * i));
		end
		apb_write(reg_addr(mrd_pkg::REG_FACTORS), w, err);
		check_bit(err, 1'b0, "pslverr");
		apb_read(reg_addr(mrd_pkg::REG_SIZE), data, err);
		check_word(data, 32'(pts) | (32'(m) << 12), "size register");
		apb_read(reg_addr(mrd_pkg::REG_FACTORS), data, err);
		check_word(data, exp, "factor register");
	endtask

	task automatic load_samples(input int count);
		logic err;
		for (int k = 0; k < count; k++)
		begin
			rng = xorshift(rng);
			ref_mem[k] = rng[15:0];
			apb_write(sample_addr(k), {16'h0000, rng[15:0]}, err);
			check_bit(err, 1'b0, "pslverr");
		end
	endtask

	task automatic start_frame();
		logic err;
		beats.delete();
		beat_cyc.delete();
		end_cyc.delete();
		apb_write(reg_addr(mrd_pkg::REG_CTRL), 32'h0000_0001, err);
		check_bit(err, 1'b0, "pslverr");
		@(negedge clk);
		start_cyc = cyc;
	endtask

	// Waits for the end pulse, lets the stream settle, then checks the whole frame
	task automatic check_frame();
		mrd_pkg::src_stream_t exp;
		int n_beats;
		while (end_cyc.size() == 0)
			@(posedge clk);
		repeat (10) @(posedge clk);
		n_beats = beats.size();
		if (n_beats != cfg_pts)
			report_failure($sformatf("frame carried %0d beats, expected %0d", n_beats, cfg_pts));
		for (int n = 0; n < n_beats && n < cfg_pts; n++)
		begin
			exp.valid = 1'b1;
			exp.sop = (n == 0);
			exp.eop = (n == cfg_pts - 1);
			exp.data = ref_mem[ref_addr(n)];
			check_stream(beats[n], exp, $sformatf("src_out beat %0d", n));
		end
		if (n_beats > 0)
		begin
			if (beat_cyc[0] != start_cyc + 4)
				report_failure("first beat did not come four cycles after start");
			if (beat_cyc[n_beats-1] != beat_cyc[0] + n_beats - 1)
				report_failure("valid was not high on consecutive cycles");
			if (end_cyc[0] != beat_cyc[n_beats-1] + 1)
				report_failure("source_end did not follow the last beat by one cycle");
		end
		if (end_cyc.size() != 1)
			report_failure($sformatf("saw %0d source_end pulses instead of one", end_cyc.size()));
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_bit(src_out.valid, 1'b0, "src_out.valid");
		check_bit(src_out.sop, 1'b0, "src_out.sop");
		check_bit(src_out.eop, 1'b0, "src_out.eop");
		check_bit(source_end, 1'b0, "source_end");
		read_status(1'b0);
	endtask

	task automatic test_config_regs();
		logic [31:0] data;
		logic err;
		write_config(12, 2, 4, 3, 0);
		apb_write(reg_addr(mrd_pkg::REG_CTRL), 32'hffff_fffe, err);
		check_bit(err, 1'b0, "pslverr");
		apb_read(reg_addr(mrd_pkg::REG_CTRL), data, err);
		check_word(data, 32'h0, "control register");
		apb_write(reg_addr(14'h0010), 32'h1234_5678, err);
		check_bit(err, 1'b1, "pslverr");
	endtask

	task automatic test_single_factor();
		logic err;
		write_config(7, 1, 7, 0, 0);
		load_samples(7);
		// Index 448 would alias onto sample 0 if it were not rejected
		apb_write(sample_addr(SAMPLES), 32'h0000_dead, err);
		check_bit(err, 1'b1, "pslverr");
		start_frame();
		check_frame();
	endtask

	task automatic test_mixed_radix();
		write_config(60, 3, 3, 4, 5);
		load_samples(60);
		start_frame();
		read_status(1'b1);
		check_frame();
		read_status(1'b0);
	endtask

	task automatic test_busy_start();
		logic err;
		start_frame();
		apb_write(reg_addr(mrd_pkg::REG_CTRL), 32'h0000_0001, err);
		check_bit(err, 1'b0, "pslverr");
		check_frame();
		read_status(1'b0);
		write_config(12, 2, 4, 3, 0);
		load_samples(12);
		start_frame();
		check_frame();
	endtask

	initial
	begin
		rst_n <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_config_regs();
		test_single_factor();
		test_mixed_radix();
		test_busy_start();
		$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
verilog/mrd_pkg.sv
verilog/mrd_apb_regs.sv
verilog/mrd_cta_addr.sv
verilog/mrd_bank_map.sv
verilog/mrd_bank_ram.sv
verilog/mrd_source_ctrl.sv
verilog/mrd_source_top.sv
tests/tb_clk.sv
tests/mrd_source_tb.sv

// ==== Makefile ====
TOP = mrd_source_tb

.PHONY: compile run clean

compile:
	verilator --binary -j 0 --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
